//--- verilog/snac_pkg.sv
// shared types and constants for the SNAC adapter, imported by every RTL module and the testbench
`default_nettype none

package snac_pkg;

    // pad-type code as written by the host core
    typedef enum logic [4:0] {
        PAD_DISABLED = 5'd0,
        PAD_DB15     = 5'd1,
        PAD_NES      = 5'd2,
        PAD_SNES     = 5'd3,
        PAD_PCE_2BTN = 5'd4
    } pad_type_t;

    // one player's buttons, 1 means pressed
    typedef logic [15:0] btn_word_t;

    // phase increment of the strobe accumulator
    typedef logic [31:0] strobe_step_t;

    // serial bit counter, wide enough to count a full DB15 scan
    typedef logic [4:0] bit_cnt_t;

    localparam int unsigned CLK_FREQ_HZ = 50_000_000;

    // strobe ticks at twice the polling rate
    // so one pad clock period spans two strobes
    function automatic strobe_step_t calc_step(input int unsigned poll_hz);
        logic [63:0] step_wide;
        step_wide = (64'd1 << 32) * 64'(2 * poll_hz) / 64'(CLK_FREQ_HZ);
        return strobe_step_t'(step_wide);
    endfunction

    localparam strobe_step_t SERLAT_STEP = calc_step(200_000);
    localparam strobe_step_t SNES_STEP   = calc_step(50_000);
    localparam strobe_step_t PCE_STEP    = calc_step(40_000);

    // serial bits per scan for each pad family
    localparam bit_cnt_t DB15_BITS = 5'd16;
    localparam bit_cnt_t NES_BITS  = 5'd8;
    localparam bit_cnt_t SNES_BITS = 5'd12;

    // synchronized cartridge inputs, all active low from the pad
    typedef struct packed {
        logic in4;
        logic in7;
        logic io3;
        logic io6;
    } snac_in_t;

    // pad-side drive lines from a reader
    typedef struct packed {
        logic out1;
        logic out2;
        logic io5;
    } snac_drive_t;

    // reader result as seen by the output stage
    typedef struct packed {
        btn_word_t p1;
        btn_word_t p2;
        logic      busy;
        logic      active;
    } pad_frame_t;

endpackage

`default_nettype wire

//--- verilog/snac_poll_timer.sv
// strobe generator, holds the pad type and restarts the readers whenever the type changes
`default_nettype none

module snac_poll_timer (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  snac_pkg::pad_type_t i_pad_type,
    output logic                o_restart,
    output logic                o_stb
);
    import snac_pkg::*;

    pad_type_t    type_q;
    pad_type_t    type_prev_q;
    logic         restart_q;
    strobe_step_t acc_q;
    strobe_step_t step;
    logic         stb_q;

    // step picked per pad family
    // a disabled or unknown type adds nothing so no strobe ever fires
    always_comb begin
        case (type_q)
            PAD_DB15:           step = SERLAT_STEP;
            PAD_NES, PAD_SNES:  step = SNES_STEP;
            PAD_PCE_2BTN:       step = PCE_STEP;
            default:            step = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            type_q      <= PAD_DISABLED;
            type_prev_q <= PAD_DISABLED;
            restart_q   <= 1'b0;
            acc_q       <= '0;
            stb_q       <= 1'b0;
        end else begin
            type_q      <= i_pad_type;
            type_prev_q <= type_q;
            // change seen one cycle after the type register
            restart_q   <= (type_q != type_prev_q);
            if (restart_q) begin
                acc_q <= '0;
                stb_q <= 1'b0;
            end else begin
                // carry out of the accumulator is the strobe
                {stb_q, acc_q} <= {1'b0, acc_q} + {1'b0, step};
            end
        end
    end

    assign o_restart = restart_q;
    assign o_stb     = stb_q;

endmodule

`default_nettype wire

//--- verilog/serlatch_reader.sv
// latch and clock reader for DB15, NES and SNES pads, scans two pads side by side
`default_nettype none

module serlatch_reader (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  snac_pkg::pad_type_t   i_pad_type,
    input  logic                  i_restart,
    input  logic                  i_stb,
    input  snac_pkg::snac_in_t    i_pins,
    output snac_pkg::snac_drive_t o_drive,
    output snac_pkg::pad_frame_t  o_frame
);
    import snac_pkg::*;

    typedef enum logic [1:0] {IDLE, LATCH, CLK_LOW, CLK_HIGH} state_t;

    state_t    state_q;
    pad_type_t type_q;
    bit_cnt_t  bit_idx_q;
    bit_cnt_t  bit_cnt;
    btn_word_t sr_p1_q;
    btn_word_t sr_p2_q;
    btn_word_t p1_q;
    btn_word_t p2_q;
    logic      busy_q;
    logic      active;
    logic      dat1;

    // bits per scan, zero means the type is not ours
    always_comb begin
        case (type_q)
            PAD_DB15: bit_cnt = DB15_BITS;
            PAD_NES:  bit_cnt = NES_BITS;
            PAD_SNES: bit_cnt = SNES_BITS;
            default:  bit_cnt = '0;
        endcase
    end

    assign active = (bit_cnt != '0);

    // DB15 pad 1 may come in on either data line, a low on one of them wins
    assign dat1 = (type_q == PAD_DB15) ? (i_pins.io3 & i_pins.io6) : i_pins.io3;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= IDLE;
            type_q    <= PAD_DISABLED;
            bit_idx_q <= '0;
            busy_q    <= 1'b0;
            p1_q      <= '0;
            p2_q      <= '0;
        end else begin
            type_q <= i_pad_type;
            if (i_restart) begin
                // abort the scan and drop stale buttons
                state_q   <= IDLE;
                bit_idx_q <= '0;
                busy_q    <= 1'b0;
                p1_q      <= '0;
                p2_q      <= '0;
            end else if (i_stb) begin
                case (state_q)
                    IDLE: begin
                        if (active) begin
                            state_q   <= LATCH;
                            bit_idx_q <= '0;
                            busy_q    <= 1'b1;
                        end
                    end
                    LATCH: begin
                        state_q <= CLK_LOW;
                    end
                    CLK_LOW: begin
                        // sample taken here, before the rising edge reaches the pad
                        state_q   <= CLK_HIGH;
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                    CLK_HIGH: begin
                        if (bit_idx_q >= bit_cnt) begin
                            state_q <= IDLE;
                            busy_q  <= 1'b0;
                            p1_q    <= sr_p1_q;
                            p2_q    <= sr_p2_q;
                        end else begin
                            state_q <= CLK_LOW;
                        end
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // shift registers, cleared on latch so unused upper bits read 0
    always_ff @(posedge i_clk) begin
        if (i_stb && state_q == LATCH) begin
            sr_p1_q <= '0;
            sr_p2_q <= '0;
        end else if (i_stb && state_q == CLK_LOW) begin
            sr_p1_q[bit_idx_q[3:0]] <= ~dat1;
            sr_p2_q[bit_idx_q[3:0]] <= ~i_pins.in7;
        end
    end

    // both pads share latch, each gets its own clock line
    assign o_drive = '{out1: (state_q == CLK_HIGH),
                       out2: (state_q == LATCH),
                       io5:  (state_q == CLK_HIGH)};

    assign o_frame = '{p1: p1_q, p2: p2_q, busy: busy_q, active: active};

endmodule

`default_nettype wire

//--- verilog/pce_reader.sv
// PC Engine 2-button reader, one pad read as a direction nibble and a button nibble
`default_nettype none

module pce_reader (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  snac_pkg::pad_type_t   i_pad_type,
    input  logic                  i_restart,
    input  logic                  i_stb,
    input  snac_pkg::snac_in_t    i_pins,
    output snac_pkg::snac_drive_t o_drive,
    output snac_pkg::pad_frame_t  o_frame
);
    import snac_pkg::*;

    typedef enum logic [1:0] {IDLE, CLEAR, SEL_HIGH, SEL_LOW} state_t;

    state_t    state_q;
    pad_type_t type_q;
    logic      busy_q;
    logic      active;
    logic [3:0] pad_nib;
    logic [3:0] dir_q;
    btn_word_t p1_q;

    assign active = (type_q == PAD_PCE_2BTN);

    // pin order gives up/right/down/left or I/II/select/run
    assign pad_nib = {i_pins.in4, i_pins.io6, i_pins.io3, i_pins.in7};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            type_q  <= PAD_DISABLED;
            busy_q  <= 1'b0;
            p1_q    <= '0;
        end else begin
            type_q <= i_pad_type;
            if (i_restart) begin
                state_q <= IDLE;
                busy_q  <= 1'b0;
                p1_q    <= '0;
            end else if (i_stb) begin
                case (state_q)
                    IDLE: begin
                        if (active) begin
                            state_q <= CLEAR;
                            busy_q  <= 1'b1;
                        end
                    end
                    CLEAR: begin
                        state_q <= SEL_HIGH;
                    end
                    SEL_HIGH: begin
                        state_q <= SEL_LOW;
                    end
                    SEL_LOW: begin
                        // pins still show the select-low nibble here
                        state_q <= IDLE;
                        busy_q  <= 1'b0;
                        p1_q    <= {8'h00, ~pad_nib, dir_q};
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // directions held a full strobe period after select rose
    always_ff @(posedge i_clk) begin
        if (i_stb && state_q == SEL_HIGH) begin
            dir_q <= ~pad_nib;
        end
    end

    // clear on out1, select on out2, io5 unused by this pad
    assign o_drive = '{out1: (state_q == CLEAR),
                       out2: (state_q == SEL_HIGH),
                       io5:  1'b0};

    // single pad so player 2 stays empty
    assign o_frame = '{p1: p1_q, p2: '0, busy: busy_q, active: active};

endmodule

`default_nettype wire

//--- verilog/snac_port_mux.sv
// cartridge port stage, syncs pad inputs and registers the active reader onto pins and words
`default_nettype none

module snac_port_mux (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic [7:4]            i_bk0,
    input  logic                  i_pin31,
    input  snac_pkg::snac_drive_t i_serlat_drive,
    input  snac_pkg::snac_drive_t i_pce_drive,
    input  snac_pkg::pad_frame_t  i_serlat_frame,
    input  snac_pkg::pad_frame_t  i_pce_frame,
    output snac_pkg::snac_in_t    o_pins,
    output logic [1:0]            o_bk1_p76,
    output logic                  o_bk0_dir,
    output logic                  o_pin30,
    output logic                  o_pin30_dir,
    output logic                  o_pin31_dir,
    output snac_pkg::btn_word_t   o_p1_btn,
    output snac_pkg::btn_word_t   o_p2_btn,
    output logic                  o_busy
);
    import snac_pkg::*;

    pad_frame_t  sel_frame;
    snac_drive_t sel_drive;

    // only one reader claims a type, nothing claimed means all quiet
    always_comb begin
        sel_frame = '0;
        sel_drive = '0;
        if (i_serlat_frame.active) begin
            sel_frame = i_serlat_frame;
            sel_drive = i_serlat_drive;
        end else if (i_pce_frame.active) begin
            sel_frame = i_pce_frame;
            sel_drive = i_pce_drive;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pins    <= '0;
            o_bk1_p76 <= '0;
            o_pin30   <= 1'b0;
            o_p1_btn  <= '0;
            o_p2_btn  <= '0;
            o_busy    <= 1'b0;
        end else begin
            // config A input mapping, bk0[6] is not used here
            o_pins    <= '{in4: i_bk0[7], in7: i_bk0[5], io3: i_bk0[4], io6: i_pin31};
            // bk1[7] carries out2, bk1[6] carries out1
            o_bk1_p76 <= {sel_drive.out2, sel_drive.out1};
            o_pin30   <= sel_drive.io5;
            o_p1_btn  <= sel_frame.p1;
            o_p2_btn  <= sel_frame.p2;
            o_busy    <= sel_frame.busy;
        end
    end

    // config A directions, bk0 and pin31 in, pin30 out
    assign o_bk0_dir   = 1'b0;
    assign o_pin30_dir = 1'b1;
    assign o_pin31_dir = 1'b0;

endmodule

`default_nettype wire

//--- verilog/snac_top.sv
// SNAC adapter top level, connect the cartridge port and read two player words
`default_nettype none

module snac_top (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  snac_pkg::pad_type_t i_pad_type,
    input  logic [7:4]          i_cart_bk0,
    input  logic                i_cart_pin31,
    output logic [1:0]          o_cart_bk1_p76,
    output logic                o_cart_bk0_dir,
    output logic                o_cart_pin30,
    output logic                o_cart_pin30_dir,
    output logic                o_cart_pin31_dir,
    output snac_pkg::btn_word_t o_p1_btn,
    output snac_pkg::btn_word_t o_p2_btn,
    output logic                o_busy,
    output logic                o_stb
);
    import snac_pkg::*;

    logic        restart;
    snac_in_t    pins;
    snac_drive_t serlat_drive;
    snac_drive_t pce_drive;
    pad_frame_t  serlat_frame;
    pad_frame_t  pce_frame;

    // strobe also leaves the top for observation
    snac_poll_timer i_snac_poll_timer (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_pad_type (i_pad_type),
        .o_restart  (restart),
        .o_stb      (o_stb)
    );

    serlatch_reader i_serlatch_reader (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_pad_type (i_pad_type),
        .i_restart  (restart),
        .i_stb      (o_stb),
        .i_pins     (pins),
        .o_drive    (serlat_drive),
        .o_frame    (serlat_frame)
    );

    pce_reader i_pce_reader (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_pad_type (i_pad_type),
        .i_restart  (restart),
        .i_stb      (o_stb),
        .i_pins     (pins),
        .o_drive    (pce_drive),
        .o_frame    (pce_frame)
    );

    snac_port_mux i_snac_port_mux (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_bk0          (i_cart_bk0),
        .i_pin31        (i_cart_pin31),
        .i_serlat_drive (serlat_drive),
        .i_pce_drive    (pce_drive),
        .i_serlat_frame (serlat_frame),
        .i_pce_frame    (pce_frame),
        .o_pins         (pins),
        .o_bk1_p76      (o_cart_bk1_p76),
        .o_bk0_dir      (o_cart_bk0_dir),
        .o_pin30        (o_cart_pin30),
        .o_pin30_dir    (o_cart_pin30_dir),
        .o_pin31_dir    (o_cart_pin31_dir),
        .o_p1_btn       (o_p1_btn),
        .o_p2_btn       (o_p2_btn),
        .o_busy         (o_busy)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// testbench clock and reset source, 10 unit period with reset held low for the first 3 cycles
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // release away from the rising edge
    initial begin
        o_arst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/snac_tb.sv
// self-checking testbench for the SNAC adapter that runs a table of pad scans against behavioral pads
`default_nettype none

module snac_tb;
    import snac_pkg::*;

    // one table row with pad type, both pad words and the words the DUT should report
    typedef struct packed {
        pad_type_t pad_type;
        btn_word_t w1;
        btn_word_t w2;
        btn_word_t exp_p1;
        btn_word_t exp_p2;
    } test_row_t;

    localparam int     NUM_ROWS        = 10;
    localparam int     CLK_PERIOD      = 10;
    localparam int     DISABLED_WINDOW = 2000;
    // SNES is the slowest scan
    // wait for first strobe, latch, then two strobes per bit
    localparam longint SNES_STB_CYCLES = (longint'(1) << 32) / longint'(SNES_STEP);
    localparam longint SCAN_MAX_CYCLES = (2 * longint'(SNES_BITS) + 3) * SNES_STB_CYCLES;
    localparam longint WATCHDOG_TIME   =
        (NUM_ROWS * 3 * SCAN_MAX_CYCLES + 2 * DISABLED_WINDOW + 100) * CLK_PERIOD;

    logic        clk;
    logic        arst_n;
    pad_type_t   pad_type;
    logic [7:4]  cart_bk0 = 4'hf;
    logic        cart_pin31 = 1'b1;
    logic [1:0]  cart_bk1_p76;
    logic        cart_bk0_dir;
    logic        cart_pin30;
    logic        cart_pin30_dir;
    logic        cart_pin31_dir;
    btn_word_t   p1_btn;
    btn_word_t   p2_btn;
    logic        busy;
    logic        stb;

    // pad model state
    btn_word_t   model_w1;
    btn_word_t   model_w2;
    btn_word_t   held_w1 = '0;
    btn_word_t   held_w2 = '0;
    int          idx1 = 0;
    int          idx2 = 0;
    logic        clk1_prev = 1'b0;
    logic        clk2_prev = 1'b0;

    test_row_t   rows [0:NUM_ROWS-1];
    logic [31:0] lcg_state;
    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;

    tb_clock_gen i_tb_clock_gen (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    snac_top i_snac_top (
        .i_clk            (clk),
        .i_arst_n         (arst_n),
        .i_pad_type       (pad_type),
        .i_cart_bk0       (cart_bk0),
        .i_cart_pin31     (cart_pin31),
        .o_cart_bk1_p76   (cart_bk1_p76),
        .o_cart_bk0_dir   (cart_bk0_dir),
        .o_cart_pin30     (cart_pin30),
        .o_cart_pin30_dir (cart_pin30_dir),
        .o_cart_pin31_dir (cart_pin31_dir),
        .o_p1_btn         (p1_btn),
        .o_p2_btn         (p2_btn),
        .o_busy           (busy),
        .o_stb            (stb)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // p1 as the pad rules define it for each family
    function automatic btn_word_t expect_p1(input pad_type_t t, input btn_word_t w);
        case (t)
            PAD_DB15:     return w;
            PAD_NES:      return w & 16'h00ff;
            PAD_SNES:     return w & 16'h0fff;
            PAD_PCE_2BTN: return {8'h00, w[7:0]};
            default:      return 16'h0000;
        endcase
    endfunction

    // PC Engine has no second pad
    function automatic btn_word_t expect_p2(input pad_type_t t, input btn_word_t w);
        case (t)
            PAD_DB15: return w;
            PAD_NES:  return w & 16'h00ff;
            PAD_SNES: return w & 16'h0fff;
            default:  return 16'h0000;
        endcase
    endfunction

    task automatic compare_word(input btn_word_t got, input btn_word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_pin(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic make_random_row(input pad_type_t t, output test_row_t row);
        btn_word_t w1;
        btn_word_t w2;
        lcg_state = lcg_next(lcg_state);
        w1 = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        w2 = lcg_state[31:16];
        row = '{t, w1, w2, expect_p1(t, w1), expect_p2(t, w2)};
    endtask

    task automatic fill_rows();
        // upper bits set so that masking to the bit count shows
        rows[0] = '{PAD_SNES, 16'hffff, 16'ha5c3, 16'h0fff, 16'h05c3};
        rows[1] = '{PAD_NES, 16'hf0a5, 16'h7e81, 16'h00a5, 16'h0081};
        rows[2] = '{PAD_DB15, 16'h8001, 16'h5a5a, 16'h8001, 16'h5a5a};
        make_random_row(PAD_DB15, rows[3]);
        rows[4] = '{PAD_PCE_2BTN, 16'hff3c, 16'hbeef, 16'h003c, 16'h0000};
        make_random_row(PAD_PCE_2BTN, rows[5]);
        rows[6] = '{PAD_DISABLED, 16'h1234, 16'h5678, 16'h0000, 16'h0000};
        // back from disabled
        make_random_row(PAD_SNES, rows[7]);
        make_random_row(PAD_NES, rows[8]);
        rows[9] = '{PAD_PCE_2BTN, 16'h00c5, 16'hffff, 16'h00c5, 16'h0000};
    endtask

    task automatic wait_busy_falls(input int count);
        int   seen;
        logic busy_prev;
        seen = 0;
        busy_prev = busy;
        while (seen < count) begin
            @(negedge clk);
            if (busy_prev && !busy) begin
                seen++;
            end
            busy_prev = busy;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", num, name, error_count - errs_before);
        end
    endtask

    task automatic check_reset_state();
        compare_pin(busy, 1'b0, "o_busy in reset");
        compare_pin(stb, 1'b0, "o_stb in reset");
        compare_pin(cart_bk1_p76[0], 1'b0, "bk1[6] in reset");
        compare_pin(cart_bk1_p76[1], 1'b0, "bk1[7] in reset");
        compare_pin(cart_pin30, 1'b0, "pin30 in reset");
        compare_word(p1_btn, 16'h0000, "p1 in reset");
        compare_word(p2_btn, 16'h0000, "p2 in reset");
        compare_pin(cart_bk0_dir, 1'b0, "bk0 direction");
        compare_pin(cart_pin30_dir, 1'b1, "pin30 direction");
        compare_pin(cart_pin31_dir, 1'b0, "pin31 direction");
    endtask

    // strobe, words and drives all quiet over the disabled window
    task automatic check_disabled_window();
        int errs_start;
        errs_start = error_count;
        // type register and restart pulse need a few cycles
        repeat (8) @(negedge clk);
        for (int n = 0; n < DISABLED_WINDOW && error_count == errs_start; n++) begin
            @(negedge clk);
            compare_pin(stb, 1'b0, "o_stb while disabled");
            compare_word(p1_btn, 16'h0000, "p1 while disabled");
            compare_word(p2_btn, 16'h0000, "p2 while disabled");
            compare_pin(cart_bk1_p76[0], 1'b0, "bk1[6] while disabled");
            compare_pin(cart_bk1_p76[1], 1'b0, "bk1[7] while disabled");
            compare_pin(cart_pin30, 1'b0, "pin30 while disabled");
        end
    endtask

    // behavioral pads read DUT outputs at the falling edge where they are stable
    always @(negedge clk) begin : pad_model
        logic       d1;
        logic       d2;
        logic [3:0] nib;
        case (pad_type)
            PAD_DB15, PAD_NES, PAD_SNES: begin
                if (cart_bk1_p76[1]) begin
                    // latch reloads both pads and bit 0 goes out first
                    held_w1 = model_w1;
                    held_w2 = model_w2;
                    idx1 = 0;
                    idx2 = 0;
                end else begin
                    // pad 1 clocked on bk1[6], pad 2 on pin30
                    if (cart_bk1_p76[0] && !clk1_prev) begin
                        idx1++;
                    end
                    if (cart_pin30 && !clk2_prev) begin
                        idx2++;
                    end
                end
                // active low and released once the word runs out
                d1 = (idx1 < 16) ? ~held_w1[idx1] : 1'b1;
                d2 = (idx2 < 16) ? ~held_w2[idx2] : 1'b1;
                // DB15 pad 1 pulls only one line at a time
                // even bits on io3, odd bits on io6
                if (pad_type == PAD_DB15 && idx1 % 2 == 1) begin
                    cart_bk0   <= {2'b11, d2, 1'b1};
                    cart_pin31 <= d1;
                end else begin
                    cart_bk0   <= {2'b11, d2, d1};
                    cart_pin31 <= 1'b1;
                end
            end
            PAD_PCE_2BTN: begin
                // clear on bk1[6] pulls every line low
                // select high shows up/right/down/left
                // select low shows I/II/select/run
                if (cart_bk1_p76[0]) begin
                    nib = 4'h0;
                end else begin
                    nib = cart_bk1_p76[1] ? ~model_w1[3:0] : ~model_w1[7:4];
                end
                // in4, io6, io3, in7 carry nibble bits 3 to 0
                cart_bk0   <= {nib[3], 1'b1, nib[0], nib[1]};
                cart_pin31 <= nib[2];
            end
            default: begin
                cart_bk0   <= 4'hf;
                cart_pin31 <= 1'b1;
            end
        endcase
        clk1_prev = cart_bk1_p76[0];
        clk2_prev = cart_pin30;
    end

    initial begin
        test_row_t row;
        int        errs_before;
        int        falls;
        pad_type_t prev_type;
        pad_type     = PAD_DISABLED;
        model_w1     = '0;
        model_w2     = '0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        lcg_state    = 32'h1c04_bf78;
        fill_rows();

        // second falling edge still lies inside the 3 reset cycles
        repeat (2) @(negedge clk);
        errs_before = error_count;
        check_reset_state();
        report_test(0, "reset", errs_before);
        wait (arst_n === 1'b1);

        prev_type = PAD_DISABLED;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = rows[i];
            errs_before = error_count;
            @(negedge clk);
            pad_type <= row.pad_type;
            model_w1 <= row.w1;
            model_w2 <= row.w2;
            if (row.pad_type == PAD_DISABLED) begin
                check_disabled_window();
            end else begin
                // restart clears both words long before the next scan ends
                if (prev_type != PAD_DISABLED && prev_type != row.pad_type) begin
                    repeat (8) @(negedge clk);
                    compare_word(p1_btn, 16'h0000, "p1 after type change");
                    compare_word(p2_btn, 16'h0000, "p2 after type change");
                end
                // coming from disabled the first scan is already clean
                // otherwise the first fall may end an aborted or mixed scan
                falls = (prev_type == PAD_DISABLED) ? 1 : 2;
                wait_busy_falls(falls);
                compare_word(p1_btn, row.exp_p1, "p1 word");
                compare_word(p2_btn, row.exp_p2, "p2 word");
            end
            report_test(i + 1, row.pad_type.name(), errs_before);
            prev_type = row.pad_type;
        end

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // bounds the run by the slowest scan for every row
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the test table did not finish before the watchdog expired");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/snac_pkg.sv
verilog/snac_poll_timer.sv
verilog/serlatch_reader.sv
verilog/pce_reader.sv
verilog/snac_port_mux.sv
verilog/snac_top.sv
verification/tb_clock_gen.sv
verification/snac_tb.sv

//--- Bender.yml
package:
  name: snac_adapter

sources:
  - files:
      - verilog/snac_pkg.sv
      - verilog/snac_poll_timer.sv
      - verilog/serlatch_reader.sv
      - verilog/pce_reader.sv
      - verilog/snac_port_mux.sv
      - verilog/snac_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/snac_tb.sv
